/* hdl/nn_config.svh */
`ifndef NN_CONFIG_SVH
`define NN_CONFIG_SVH

// Network dimensions
`define NN_INPUT_SIZE   16
`define NN_HIDDEN_SIZE  8
`define NN_OUTPUT_SIZE  4

// Fixed-point widths
`define NN_DATA_WIDTH   16
`define NN_ACC_WIDTH    24
`define NN_FRAC_BITS    12   // Q4.12 weights and activations

// MAC lanes per cycle
`define NN_LANES        4

`endif

/* hdl/nn_pkg.sv */
`default_nettype none
`include "nn_config.svh"

package nn_pkg;

    typedef logic signed [`NN_DATA_WIDTH-1:0] data_t;
    typedef logic signed [`NN_ACC_WIDTH-1:0]  acc_t;

    typedef logic [$clog2(`NN_INPUT_SIZE)-1:0]  in_idx_t;
    typedef logic [$clog2(`NN_HIDDEN_SIZE)-1:0] hid_idx_t;
    typedef logic [$clog2(`NN_OUTPUT_SIZE)-1:0] out_idx_t;
    typedef logic [$clog2(`NN_OUTPUT_SIZE)-1:0] label_t;

    typedef enum logic [2:0] {
        H_IDLE, H_CLEAR, H_MAC, H_ACCUM, H_BIAS, H_RELU, H_DONE
    } hidden_state_e;

    typedef enum logic [2:0] {
        O_IDLE, O_LOAD_BIAS, O_MAC, O_NEXT_NODE, O_DONE
    } output_state_e;

endpackage

`default_nettype wire

/* hdl/mac_if.sv */
`timescale 1ns/1ps
`default_nettype none
`include "nn_config.svh"

interface mac_if import nn_pkg::*; ();

    data_t                      act [0:`NN_LANES-1];
    data_t                      wgt [0:`NN_LANES-1];
    logic [$clog2(`NN_LANES):0] count;   // Active lanes, 1 to LANES
    acc_t                       sum;     // Same-cycle result

    modport layer (output act, output wgt, output count, input sum);
    modport mac   (input act, input wgt, input count, output sum);

endinterface

`default_nettype wire

/* hdl/mac_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "nn_config.svh"

module mac_unit import nn_pkg::*; (
    mac_if.mac mac
);

    logic signed [2*`NN_DATA_WIDTH-1:0] prod     [0:`NN_LANES-1];
    acc_t                               lane_val [0:`NN_LANES-1];

    // Full-width product, then drop the fraction bits
    always_comb begin
        for (int m = 0; m < `NN_LANES; m++) begin
            prod[m] = mac.act[m] * mac.wgt[m];
            if (m < int'(mac.count)) begin
                lane_val[m] = acc_t'(prod[m] >>> `NN_FRAC_BITS);   // Fits easily in 24 bits
            end else begin
                lane_val[m] = '0;
            end
        end
    end

    // Adder tree is left to synthesis
    always_comb begin
        acc_t total;
        total = '0;
        for (int m = 0; m < `NN_LANES; m++) begin
            total = total + lane_val[m];
        end
        mac.sum = total;
    end

endmodule

`default_nettype wire

/* hdl/hidden_layer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "nn_config.svh"

module hidden_layer import nn_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  i_start,
    input  wire data_t i_data     [0:`NN_INPUT_SIZE-1],
    input  wire data_t i_w1_chunk [0:`NN_LANES-1],
    input  wire data_t i_b1_chunk [0:`NN_LANES-1],
    output logic       o_done,
    output data_t      o_hidden   [0:`NN_HIDDEN_SIZE-1],
    output in_idx_t    o_w1_base_idx,
    output hid_idx_t   o_w1_node_idx,
    output hid_idx_t   o_b1_base_idx
);

    hidden_state_e                    state;
    logic [$clog2(`NN_HIDDEN_SIZE):0] node_cnt;   // Spare top bit for the range check
    hid_idx_t                         node_idx;
    in_idx_t                          base;       // Input index of lane 0
    hid_idx_t                         grp_idx;    // Node group for bias and ReLU
    acc_t                             run_sum;
    acc_t                             acc [0:`NN_HIDDEN_SIZE-1];

    mac_if   u_mac_if ();
    mac_unit u_mac_unit (.mac(u_mac_if));

    assign node_idx      = hid_idx_t'(node_cnt);
    assign o_w1_base_idx = base;
    assign o_w1_node_idx = node_idx;
    assign o_b1_base_idx = grp_idx;
    assign o_done        = (state == H_DONE);

    // ReLU with clamp at the top of the 16-bit range
    function automatic data_t relu_sat(acc_t a);
        data_t max_pos;
        max_pos = {1'b0, {(`NN_DATA_WIDTH-1){1'b1}}};
        if (a < 0) begin
            return '0;
        end
        if (a > acc_t'(max_pos)) begin
            return max_pos;
        end
        return a[`NN_DATA_WIDTH-1:0];
    endfunction

    // Feed the MAC lanes, lanes past the vector end stay idle
    always_comb begin
        int rem;
        rem = `NN_INPUT_SIZE - int'(base);
        if (rem > `NN_LANES) begin
            rem = `NN_LANES;
        end
        u_mac_if.count = rem[$clog2(`NN_LANES):0];
        for (int m = 0; m < `NN_LANES; m++) begin
            u_mac_if.wgt[m] = i_w1_chunk[m];
            if (m < rem) begin
                u_mac_if.act[m] = i_data[int'(base) + m];
            end else begin
                u_mac_if.act[m] = '0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= H_IDLE;
            node_cnt <= '0;
            base     <= '0;
            grp_idx  <= '0;
        end else begin
            case (state)
                H_IDLE: begin
                    if (i_start) begin
                        state <= H_CLEAR;
                    end
                end
                H_CLEAR: begin
                    node_cnt <= '0;
                    base     <= '0;
                    state    <= H_MAC;
                end
                H_MAC: begin
                    if (int'(base) + `NN_LANES < `NN_INPUT_SIZE) begin
                        base <= base + in_idx_t'(`NN_LANES);
                    end else begin
                        state <= H_ACCUM;
                    end
                end
                H_ACCUM: begin
                    base <= '0;
                    if (int'(node_cnt) < `NN_HIDDEN_SIZE - 1) begin
                        node_cnt <= node_cnt + 1'b1;
                        state    <= H_MAC;
                    end else begin
                        grp_idx <= '0;
                        state   <= H_BIAS;
                    end
                end
                H_BIAS: begin
                    if (int'(grp_idx) + `NN_LANES < `NN_HIDDEN_SIZE) begin
                        grp_idx <= grp_idx + hid_idx_t'(`NN_LANES);
                    end else begin
                        grp_idx <= '0;
                        state   <= H_RELU;
                    end
                end
                H_RELU: begin
                    if (int'(grp_idx) + `NN_LANES < `NN_HIDDEN_SIZE) begin
                        grp_idx <= grp_idx + hid_idx_t'(`NN_LANES);
                    end else begin
                        state <= H_DONE;
                    end
                end
                H_DONE:  state <= H_IDLE;   // o_done is high here
                default: state <= H_IDLE;
            endcase
        end
    end

    // Datapath registers
    always_ff @(posedge clk) begin
        case (state)
            H_CLEAR: begin
                run_sum <= '0;
                for (int k = 0; k < `NN_HIDDEN_SIZE; k++) begin
                    acc[k] <= '0;
                end
            end
            H_MAC: run_sum <= run_sum + u_mac_if.sum;
            H_ACCUM: begin
                acc[node_idx] <= acc[node_idx] + run_sum;
                run_sum       <= '0;
            end
            H_BIAS: begin
                for (int m = 0; m < `NN_LANES; m++) begin
                    if (int'(grp_idx) + m < `NN_HIDDEN_SIZE) begin
                        acc[int'(grp_idx) + m] <= acc[int'(grp_idx) + m] + acc_t'(i_b1_chunk[m]);
                    end
                end
            end
            H_RELU: begin
                for (int m = 0; m < `NN_LANES; m++) begin
                    if (int'(grp_idx) + m < `NN_HIDDEN_SIZE) begin
                        o_hidden[int'(grp_idx) + m] <= relu_sat(acc[int'(grp_idx) + m]);
                    end
                end
            end
            default: ;
        endcase
    end

    // FSM must leave the MAC phase before the node counter runs off the end
    a_node_range: assert property (@(posedge clk) disable iff (!rst_n)
        (state != H_IDLE) |-> (int'(node_cnt) < `NN_HIDDEN_SIZE))
        else $error("hidden node index out of range");

endmodule

`default_nettype wire

/* hdl/argmax_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "nn_config.svh"

module argmax_unit import nn_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  i_valid,
    input  wire data_t i_logits [0:`NN_OUTPUT_SIZE-1],
    output logic       o_valid,
    output label_t     o_label,
    output data_t      o_logits [0:`NN_OUTPUT_SIZE-1]
);

    label_t best_idx;

    // Strict compare so the lowest index wins a tie
    always_comb begin
        data_t best_val;
        best_val = i_logits[0];
        best_idx = '0;
        for (int k = 1; k < `NN_OUTPUT_SIZE; k++) begin
            if (i_logits[k] > best_val) begin
                best_val = i_logits[k];
                best_idx = label_t'(k);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_valid <= 1'b0;
            o_label <= '0;
            for (int k = 0; k < `NN_OUTPUT_SIZE; k++) begin
                o_logits[k] <= '0;
            end
        end else begin
            o_valid <= i_valid;
            if (i_valid) begin
                o_label  <= best_idx;
                o_logits <= i_logits;   // Held until the next result
            end
        end
    end

    // Depends on the output layer FSM passing through idle between results
    a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        o_valid |=> !o_valid)
        else $error("o_valid high for two cycles");

endmodule

`default_nettype wire

/* hdl/output_layer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "nn_config.svh"

module output_layer import nn_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  i_start,
    input  wire data_t i_hidden   [0:`NN_HIDDEN_SIZE-1],
    input  wire data_t i_w2_chunk [0:`NN_LANES-1],
    input  wire data_t i_b2,
    output logic       o_valid,
    output data_t      o_logits   [0:`NN_OUTPUT_SIZE-1],
    output label_t     o_label,
    output hid_idx_t   o_w2_base_idx,
    output out_idx_t   o_w2_node_idx
);

    output_state_e state;
    out_idx_t      node;
    hid_idx_t      base;
    acc_t          acc_cur;   // Logit being built
    data_t         logits [0:`NN_OUTPUT_SIZE-1];
    logic          logits_valid;

    mac_if   u_mac_if ();
    mac_unit u_mac_unit (.mac(u_mac_if));

    assign o_w2_base_idx = base;
    assign o_w2_node_idx = node;
    assign logits_valid  = (state == O_DONE);

    // Signed saturation to 16 bits
    function automatic data_t sat_logit(acc_t a);
        data_t max_pos;
        data_t min_neg;
        max_pos = {1'b0, {(`NN_DATA_WIDTH-1){1'b1}}};
        min_neg = {1'b1, {(`NN_DATA_WIDTH-1){1'b0}}};
        if (a > acc_t'(max_pos)) begin
            return max_pos;
        end
        if (a < acc_t'(min_neg)) begin
            return min_neg;
        end
        return a[`NN_DATA_WIDTH-1:0];
    endfunction

    always_comb begin
        int rem;
        rem = `NN_HIDDEN_SIZE - int'(base);
        if (rem > `NN_LANES) begin
            rem = `NN_LANES;
        end
        u_mac_if.count = rem[$clog2(`NN_LANES):0];
        for (int m = 0; m < `NN_LANES; m++) begin
            u_mac_if.wgt[m] = i_w2_chunk[m];
            if (m < rem) begin
                u_mac_if.act[m] = i_hidden[int'(base) + m];
            end else begin
                u_mac_if.act[m] = '0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= O_IDLE;
            node  <= '0;
            base  <= '0;
        end else begin
            case (state)
                O_IDLE: begin
                    if (i_start) begin
                        node  <= '0;
                        state <= O_LOAD_BIAS;
                    end
                end
                O_LOAD_BIAS: begin
                    base  <= '0;
                    state <= O_MAC;
                end
                O_MAC: begin
                    if (int'(base) + `NN_LANES < `NN_HIDDEN_SIZE) begin
                        base <= base + hid_idx_t'(`NN_LANES);
                    end else begin
                        state <= O_NEXT_NODE;
                    end
                end
                O_NEXT_NODE: begin
                    if (int'(node) < `NN_OUTPUT_SIZE - 1) begin
                        node  <= node + 1'b1;
                        state <= O_LOAD_BIAS;
                    end else begin
                        state <= O_DONE;
                    end
                end
                O_DONE:  state <= O_IDLE;
                default: state <= O_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            O_LOAD_BIAS: acc_cur <= acc_t'(i_b2);   // b2 of the current node
            O_MAC:       acc_cur <= acc_cur + u_mac_if.sum;
            O_NEXT_NODE: logits[node] <= sat_logit(acc_cur);
            default: ;
        endcase
    end

    argmax_unit u_argmax_unit (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_valid  (logits_valid),
        .i_logits (logits),
        .o_valid  (o_valid),
        .o_label  (o_label),
        .o_logits (o_logits)
    );

    a_done_to_idle: assert property (@(posedge clk) disable iff (!rst_n)
        logits_valid |=> (state == O_IDLE))
        else $error("output layer did not return to idle after logits valid");

endmodule

`default_nettype wire

/* hdl/nn_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "nn_config.svh"

module nn_core import nn_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  i_valid,
    input  wire data_t i_data     [0:`NN_INPUT_SIZE-1],
    input  wire data_t i_w1_chunk [0:`NN_LANES-1],
    input  wire data_t i_b1_chunk [0:`NN_LANES-1],
    input  wire data_t i_w2_chunk [0:`NN_LANES-1],
    input  wire data_t i_b2,
    output logic       o_valid,
    output data_t      o_logits   [0:`NN_OUTPUT_SIZE-1],
    output label_t     o_label,
    output in_idx_t    o_w1_base_idx,
    output hid_idx_t   o_w1_node_idx,
    output hid_idx_t   o_b1_base_idx,
    output hid_idx_t   o_w2_base_idx,
    output out_idx_t   o_w2_node_idx
);

    logic  hidden_done;
    data_t hidden_act [0:`NN_HIDDEN_SIZE-1];   // ReLU outputs, stable after hidden_done

    hidden_layer u_hidden_layer (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_start       (i_valid),
        .i_data        (i_data),
        .i_w1_chunk    (i_w1_chunk),
        .i_b1_chunk    (i_b1_chunk),
        .o_done        (hidden_done),
        .o_hidden      (hidden_act),
        .o_w1_base_idx (o_w1_base_idx),
        .o_w1_node_idx (o_w1_node_idx),
        .o_b1_base_idx (o_b1_base_idx)
    );

    output_layer u_output_layer (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_start       (hidden_done),
        .i_hidden      (hidden_act),
        .i_w2_chunk    (i_w2_chunk),
        .i_b2          (i_b2),
        .o_valid       (o_valid),
        .o_logits      (o_logits),
        .o_label       (o_label),
        .o_w2_base_idx (o_w2_base_idx),
        .o_w2_node_idx (o_w2_node_idx)
    );

endmodule

`default_nettype wire

/* tb/tb_nn_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "nn_config.svh"

module tb_nn_core import nn_pkg::*; ();

    localparam int N_CASES = 5;
    localparam int PERIOD  = 100;   // Clock period in ns
    localparam int TIMEOUT = 500;   // Cycles allowed for one inference
    localparam int QUIET   = 100;   // Cycles watched for a stray o_valid
    localparam int IN_RAND = 0;
    localparam int IN_MAX  = 1;
    localparam int W_RAND  = 0;
    localparam int W_RELU  = 1;     // Small W1, b1 at the negative limit
    localparam int W_SAT   = 2;
    localparam int W_TIE   = 3;

    // Stimulus table, expected columns come from the reference model
    int     in_kind    [N_CASES] = '{IN_RAND, IN_RAND, IN_MAX, IN_RAND, IN_RAND};
    int     w_kind     [N_CASES] = '{W_RAND, W_RELU, W_SAT, W_TIE, W_RAND};
    bit     busy_start [N_CASES] = '{0, 0, 0, 0, 1};   // Second start while busy
    label_t exp_label  [N_CASES];
    data_t  exp_logits [N_CASES][`NN_OUTPUT_SIZE];

    // Per-case inputs and weight memory
    data_t x_t  [N_CASES][`NN_INPUT_SIZE];
    data_t w1_t [N_CASES][`NN_INPUT_SIZE][`NN_HIDDEN_SIZE];
    data_t b1_t [N_CASES][`NN_HIDDEN_SIZE];
    data_t w2_t [N_CASES][`NN_HIDDEN_SIZE][`NN_OUTPUT_SIZE];
    data_t b2_t [N_CASES][`NN_OUTPUT_SIZE];

    logic     clk;
    logic     rst_n;
    logic     i_valid;
    data_t    i_data     [0:`NN_INPUT_SIZE-1];
    data_t    i_w1_chunk [0:`NN_LANES-1];
    data_t    i_b1_chunk [0:`NN_LANES-1];
    data_t    i_w2_chunk [0:`NN_LANES-1];
    data_t    i_b2;
    logic     o_valid;
    data_t    o_logits   [0:`NN_OUTPUT_SIZE-1];
    label_t   o_label;
    in_idx_t  o_w1_base_idx;
    hid_idx_t o_w1_node_idx;
    hid_idx_t o_b1_base_idx;
    hid_idx_t o_w2_base_idx;
    out_idx_t o_w2_node_idx;

    logic [31:0] lfsr      = 32'hc019_ecf0;
    int          cur_row   = 0;
    int          errors    = 0;
    int          checks    = 0;
    bit          timed_out = 0;

    nn_core i_dut (.*);

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit, result sign-extended to 16 bits
    function automatic data_t rand_val(int nbits);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[14:0], lfsr[0]};
        end
        if (nbits < 16 && v[nbits-1]) begin
            v = v | (16'hffff << nbits);
        end
        return data_t'(v);
    endfunction

    function automatic int clamp(int v, int lo, int hi);
        return (v < lo) ? lo : (v > hi) ? hi : v;
    endfunction

    task automatic build_case(int r);
        for (int i = 0; i < `NN_INPUT_SIZE; i++) begin
            x_t[r][i] = (in_kind[r] == IN_MAX) ? 16'sh7fff : rand_val(16);
            for (int n = 0; n < `NN_HIDDEN_SIZE; n++) begin
                // 8-bit W1 keeps every node sum well below 32768
                w1_t[r][i][n] = (w_kind[r] == W_SAT)  ? 16'sh7fff :
                                (w_kind[r] == W_RELU) ? rand_val(8) : rand_val(16);
            end
        end
        for (int n = 0; n < `NN_HIDDEN_SIZE; n++) begin
            b1_t[r][n] = (w_kind[r] == W_RELU) ? data_t'(16'h8000) :
                         (w_kind[r] == W_SAT)  ? data_t'(0) : rand_val(16);
        end
        for (int j = 0; j < `NN_HIDDEN_SIZE; j++) begin
            for (int k = 0; k < `NN_OUTPUT_SIZE; k++) begin
                w2_t[r][j][k] = (w_kind[r] == W_SAT) ? (k % 2 ? 16'sh7fff : data_t'(16'h8000)) :
                                (w_kind[r] == W_TIE && k != 0) ? w2_t[r][j][0] : rand_val(16);
            end
        end
        for (int k = 0; k < `NN_OUTPUT_SIZE; k++) begin
            b2_t[r][k] = (w_kind[r] == W_SAT) ? data_t'(0) :
                         (w_kind[r] == W_TIE && k != 0) ? b2_t[r][0] : rand_val(16);
        end
    endtask

    // Reference model of both layers and the argmax
    task automatic run_model(int r);
        int     s;
        int     h [`NN_HIDDEN_SIZE];
        label_t best;
        for (int n = 0; n < `NN_HIDDEN_SIZE; n++) begin
            s = int'(b1_t[r][n]);
            for (int i = 0; i < `NN_INPUT_SIZE; i++) begin
                s += (int'(x_t[r][i]) * int'(w1_t[r][i][n])) >>> `NN_FRAC_BITS;
            end
            h[n] = clamp(s, 0, 32767);   // ReLU with top clamp
        end
        for (int k = 0; k < `NN_OUTPUT_SIZE; k++) begin
            s = int'(b2_t[r][k]);
            for (int j = 0; j < `NN_HIDDEN_SIZE; j++) begin
                s += (h[j] * int'(w2_t[r][j][k])) >>> `NN_FRAC_BITS;
            end
            exp_logits[r][k] = data_t'(clamp(s, -32768, 32767));
        end
        best = '0;
        for (int k = 1; k < `NN_OUTPUT_SIZE; k++) begin
            if (exp_logits[r][k] > exp_logits[r][best]) begin
                best = label_t'(k);
            end
        end
        exp_label[r] = best;
    endtask

    task automatic wait_for_valid(output bit seen);
        seen = 0;
        for (int n = 0; n < TIMEOUT && !seen; n++) begin
            @(negedge clk);
            seen = o_valid;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Weight memory answers the request indices on every falling edge
    initial begin : answer_requests
        int idx;
        i_b2 = '0;
        for (int m = 0; m < `NN_LANES; m++) begin
            i_w1_chunk[m] = '0;
            i_b1_chunk[m] = '0;
            i_w2_chunk[m] = '0;
        end
        forever begin
            @(negedge clk);
            for (int m = 0; m < `NN_LANES; m++) begin
                idx           = int'(o_w1_base_idx) + m;
                i_w1_chunk[m] = (idx < `NN_INPUT_SIZE) ? w1_t[cur_row][idx][o_w1_node_idx] : '0;
                idx           = int'(o_b1_base_idx) + m;
                i_b1_chunk[m] = (idx < `NN_HIDDEN_SIZE) ? b1_t[cur_row][idx] : '0;
                idx           = int'(o_w2_base_idx) + m;
                i_w2_chunk[m] = (idx < `NN_HIDDEN_SIZE) ? w2_t[cur_row][idx][o_w2_node_idx] : '0;
            end
            i_b2 = b2_t[cur_row][o_w2_node_idx];
        end
    end

    initial begin : main_flow
        bit  seen;
        int  extra;
        time t_start;
        time lat;
        time ref_lat;
        rst_n   = 1'b0;
        i_valid = 1'b0;
        for (int r = 0; r < N_CASES; r++) begin
            build_case(r);
            run_model(r);
        end
        i_data = x_t[0];
        repeat (5) @(negedge clk);
        checks += 2;
        if (o_valid !== 1'b0) begin
            $display("FAIL o_valid after reset: got %h expected %h", o_valid, 1'b0);
            errors++;
        end
        if (o_label !== '0) begin
            $display("FAIL o_label after reset: got %h expected %h", o_label, 2'h0);
            errors++;
        end
        for (int k = 0; k < `NN_OUTPUT_SIZE; k++) begin
            checks++;
            if (o_logits[k] !== '0) begin
                $display("FAIL o_logits[%0d] after reset: got %h expected %h",
                         k, o_logits[k], 16'h0);
                errors++;
            end
        end
        rst_n = 1'b1;

        for (int r = 0; r < N_CASES && !timed_out; r++) begin
            @(negedge clk);
            cur_row = r;
            i_data  = x_t[r];
            @(negedge clk);
            i_valid = 1'b1;
            t_start = $time;
            @(negedge clk);
            i_valid = 1'b0;
            if (busy_start[r]) begin
                repeat (3) @(negedge clk);   // Hidden layer is still in its MAC phase
                i_valid = 1'b1;
                @(negedge clk);
                i_valid = 1'b0;
            end
            wait_for_valid(seen);
            if (!seen) begin
                $display("ERROR: no o_valid within %0d cycles in case %0d", TIMEOUT, r);
                errors++;
                timed_out = 1;
            end else begin
                // Latency is fixed, a restarted inference arrives late
                lat = $time - t_start;
                if (r == 0) begin
                    ref_lat = lat;
                end else begin
                    checks++;
                    if (lat != ref_lat) begin
                        $display("ERROR: case %0d took %0d cycles to o_valid, case 0 took %0d",
                                 r, lat / PERIOD, ref_lat / PERIOD);
                        errors++;
                    end
                end
                for (int k = 0; k < `NN_OUTPUT_SIZE; k++) begin
                    checks++;
                    if (o_logits[k] !== exp_logits[r][k]) begin
                        $display("FAIL o_logits[%0d] case %0d: got %h expected %h",
                                 k, r, o_logits[k], exp_logits[r][k]);
                        errors++;
                    end
                end
                checks++;
                if (o_label !== exp_label[r]) begin
                    $display("FAIL o_label case %0d: got %h expected %h",
                             r, o_label, exp_label[r]);
                    errors++;
                end
                extra = 0;
                for (int n = 0; n < QUIET; n++) begin
                    @(negedge clk);
                    if (o_valid) begin
                        extra++;
                    end
                end
                checks++;
                if (extra != 0) begin
                    $display("ERROR: case %0d gave %0d extra o_valid pulses", r, extra);
                    errors++;
                end
            end
        end

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+hdl
hdl/nn_pkg.sv
hdl/mac_if.sv
hdl/mac_unit.sv
hdl/hidden_layer.sv
hdl/argmax_unit.sv
hdl/output_layer.sv
hdl/nn_core.sv
tb/tb_nn_core.sv

/* Makefile */
SIM  := obj_dir/Vtb_nn_core
SRCS := $(shell grep -v '^+' src.f)

.PHONY: all run clean

all: run

$(SIM): src.f $(SRCS) hdl/nn_config.svh
	verilator --binary -j 0 --timing --assert -Wno-fatal -f src.f \
		--top-module tb_nn_core -o Vtb_nn_core

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -qx "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
